// ==== verilog/proc_isa_pkg.sv ====
////////////////////
// RV32I instruction fields, opcode and funct3 encodings
// and the register file port structs
////////////////////

`default_nettype none

package proc_isa_pkg;

    // Data and instruction words
    typedef logic [31:0] xlen_t;
    typedef logic [31:0] inst_t;

    // Instruction fields
    typedef logic [4:0] reg_addr_t;
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;

    ////////////////////
    // Major opcodes
    ////////////////////

    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;

    // funct7 of the base and alternate (SUB, SRA) integer forms
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    ////////////////////
    // funct3 encodings
    ////////////////////

    // Integer operations
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    // Access sizes, shared by loads and stores
    localparam funct3_t F3_BYTE   = 3'b000;
    localparam funct3_t F3_HALF   = 3'b001;
    localparam funct3_t F3_WORD   = 3'b010;
    localparam funct3_t F3_BYTE_U = 3'b100;
    localparam funct3_t F3_HALF_U = 3'b101;

    ////////////////////
    // Register file ports
    ////////////////////

    typedef struct packed {
        reg_addr_t rs1;
        reg_addr_t rs2;
    } reg_rd_req_t;

    typedef struct packed {
        xlen_t rs1_val;
        xlen_t rs2_val;
    } reg_rd_val_t;

    typedef struct packed {
        logic      wr;
        reg_addr_t rd;
        xlen_t     val;
    } reg_wr_t;

endpackage

`default_nettype wire

// ==== verilog/proc_mem_pkg.sv ====
////////////////////
// Data memory request/response channels
// and load/store exception flags
////////////////////

`default_nettype none

package proc_mem_pkg;

    typedef logic [31:0] mem_addr_t;
    typedef logic [3:0]  mem_id_t;

    // Word-aligned request, store data already in its byte lanes
    typedef struct packed {
        logic                 we;
        mem_addr_t            addr;
        proc_isa_pkg::xlen_t  wdata;
        logic [3:0]           wstrb;
        mem_id_t              id;
    } mem_req_t;

    typedef struct packed {
        proc_isa_pkg::xlen_t  rdata;
        mem_id_t              id;
    } mem_rsp_t;

    // Bit 0 misaligned load, bit 1 misaligned store
    typedef logic [1:0] lsu_exc_t;

    localparam int EXC_LOAD_MISALIGN  = 0;
    localparam int EXC_STORE_MISALIGN = 1;

endpackage

`default_nettype wire

// ==== verilog/proc_alu.sv ====
////////////////////
// Integer ALU for OP and OP-IMM, registered write-back
////////////////////

`timescale 1ns/100ps
`default_nettype none

module proc_alu import proc_isa_pkg::*; (
    input  wire         aclk,
    input  wire         aresetn,
    input  wire         i_valid,
    output logic        o_ready,
    input  wire  inst_t i_inst,
    output reg_rd_req_t o_rd_req,
    input  wire  reg_rd_val_t i_rd_val,
    output reg_wr_t     o_wr
);

    opcode_t    opcode;
    funct3_t    funct3;
    logic [6:0] funct7;
    xlen_t      imm;
    xlen_t      op1;
    xlen_t      op2;
    logic [4:0] shamt;
    logic       is_imm;
    logic       is_sub;
    logic       is_sra;
    xlen_t      result;

    logic       wr_q;
    reg_addr_t  rd_q;
    xlen_t      val_q;

    ////////////////////
    // Decode
    ////////////////////

    assign opcode = i_inst[6:0];
    assign funct3 = i_inst[14:12];
    assign funct7 = i_inst[31:25];
    assign imm    = {{20{i_inst[31]}}, i_inst[31:20]};

    assign o_rd_req.rs1 = i_inst[19:15];
    assign o_rd_req.rs2 = i_inst[24:20];

    assign is_imm = (opcode == OPC_OP_IMM);
    // ADDI has no subtract form, SRAI keeps funct7 in imm[11:5]
    assign is_sub = !is_imm && (funct7 == F7_ALT);
    assign is_sra = (funct7 == F7_ALT);

    assign op1   = i_rd_val.rs1_val;
    assign op2   = is_imm ? imm : i_rd_val.rs2_val;
    assign shamt = op2[4:0];

    ////////////////////
    // Compute
    ////////////////////

    always_comb begin
        case (funct3)
            F3_ADD_SUB: result = is_sub ? op1 - op2 : op1 + op2;
            F3_SLL:     result = op1 << shamt;
            F3_SLT:     result = {31'b0, $signed(op1) < $signed(op2)};
            F3_SLTU:    result = {31'b0, op1 < op2};
            F3_XOR:     result = op1 ^ op2;
            F3_SRL_SRA: result = is_sra ? xlen_t'($signed(op1) >>> shamt) : op1 >> shamt;
            F3_OR:      result = op1 | op2;
            default:    result = op1 & op2;
        endcase
    end

    // Single-cycle unit, never stalls
    assign o_ready = 1'b1;

    // Write strobe, x0 is never written
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_q <= 1'b0;
        end else begin
            wr_q <= i_valid && (i_inst[11:7] != '0);
        end
    end

    always_ff @(posedge aclk) begin
        if (i_valid) begin
            rd_q  <= i_inst[11:7];
            val_q <= result;
        end
    end

    assign o_wr = '{wr: wr_q, rd: rd_q, val: val_q};

endmodule

`default_nettype wire

// ==== verilog/proc_lsu.sv ====
////////////////////
// Load/store unit with alignment check and memory request FSM
////////////////////

`timescale 1ns/100ps
`default_nettype none

module proc_lsu import proc_isa_pkg::*, proc_mem_pkg::*; #(
    parameter mem_id_t MEM_ID = 4'd2
) (
    input  wire               aclk,
    input  wire               aresetn,
    input  wire               i_valid,
    output logic              o_ready,
    output logic              o_pending_read,
    input  wire  inst_t       i_inst,
    output reg_rd_req_t       o_rd_req,
    input  wire  reg_rd_val_t i_rd_val,
    output reg_wr_t           o_wr,
    output logic              o_mem_req_valid,
    output mem_req_t          o_mem_req,
    input  wire               i_mem_req_ready,
    input  wire               i_mem_rsp_valid,
    input  wire  mem_rsp_t    i_mem_rsp,
    output lsu_exc_t          o_exc
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT_RSP
    } lsu_state_t;

    lsu_state_t state;

    funct3_t    funct3;
    logic       is_store;
    xlen_t      imm;
    mem_addr_t  addr;
    logic [1:0] offset;
    logic       misaligned;
    logic       accept;
    logic [3:0] strb;
    xlen_t      lane;
    xlen_t      load_val;

    logic       we_q;
    funct3_t    funct3_q;
    reg_addr_t  rd_q;
    mem_addr_t  addr_q;
    xlen_t      wdata_q;
    logic [3:0] wstrb_q;
    lsu_exc_t   exc_q;
    logic       wr_q;
    xlen_t      wb_val_q;

    ////////////////////
    // Address generation
    ////////////////////

    assign funct3   = i_inst[14:12];
    assign is_store = (i_inst[6:0] == OPC_STORE);

    // S-type splits the immediate around rd
    assign imm = is_store ? {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]}
                          : {{20{i_inst[31]}}, i_inst[31:20]};

    assign o_rd_req.rs1 = i_inst[19:15];
    assign o_rd_req.rs2 = i_inst[24:20];

    assign addr   = i_rd_val.rs1_val + imm;
    assign offset = addr[1:0];

    always_comb begin
        case (funct3)
            F3_HALF, F3_HALF_U: misaligned = offset[0];
            F3_WORD:            misaligned = (offset != 2'b00);
            default:            misaligned = 1'b0;
        endcase
    end

    // Lane strobes of a store
    always_comb begin
        case (funct3)
            F3_BYTE: strb = 4'b0001 << offset;
            F3_HALF: strb = 4'b0011 << offset;
            default: strb = 4'b1111;
        endcase
    end

    assign accept = i_valid && o_ready;

    ////////////////////
    // Request FSM
    ////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state <= ST_IDLE;
            exc_q <= '0;
        end else begin
            exc_q <= '0;
            case (state)
                ST_IDLE: begin
                    if (accept && misaligned) begin
                        exc_q[EXC_LOAD_MISALIGN]  <= !is_store;
                        exc_q[EXC_STORE_MISALIGN] <= is_store;
                    end else if (accept) begin
                        state <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (i_mem_req_ready) begin
                        state <= we_q ? ST_IDLE : ST_WAIT_RSP;
                    end
                end
                default: begin
                    if (i_mem_rsp_valid) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // Access captured at acceptance
    always_ff @(posedge aclk) begin
        if (accept) begin
            we_q     <= is_store;
            funct3_q <= funct3;
            rd_q     <= i_inst[11:7];
            addr_q   <= addr;
            wdata_q  <= i_rd_val.rs2_val << {offset, 3'b000};
            wstrb_q  <= strb;
        end
    end

    // Exception pulse also holds ready low for its cycle
    assign o_ready        = (state == ST_IDLE) && (exc_q == '0);
    assign o_pending_read = ((state == ST_REQ) && !we_q) || (state == ST_WAIT_RSP);
    assign o_exc          = exc_q;

    assign o_mem_req_valid = (state == ST_REQ);
    assign o_mem_req = '{we:    we_q,
                         addr:  {addr_q[31:2], 2'b00},
                         wdata: wdata_q,
                         wstrb: wstrb_q,
                         id:    MEM_ID};

    ////////////////////
    // Load write-back
    ////////////////////

    assign lane = i_mem_rsp.rdata >> {addr_q[1:0], 3'b000};

    always_comb begin
        case (funct3_q)
            F3_BYTE:   load_val = {{24{lane[7]}}, lane[7:0]};
            F3_BYTE_U: load_val = {24'b0, lane[7:0]};
            F3_HALF:   load_val = {{16{lane[15]}}, lane[15:0]};
            F3_HALF_U: load_val = {16'b0, lane[15:0]};
            default:   load_val = lane;
        endcase
    end

    // The strobe marks the end of every load, x0 included
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_q <= 1'b0;
        end else begin
            wr_q <= (state == ST_WAIT_RSP) && i_mem_rsp_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if ((state == ST_WAIT_RSP) && i_mem_rsp_valid) begin
            wb_val_q <= load_val;
        end
    end

    assign o_wr = '{wr: wr_q, rd: rd_q, val: wb_val_q};

endmodule

`default_nettype wire

// ==== verilog/proc_processing.sv ====
////////////////////
// RV32I processing unit, dispatches to the ALU and the LSU
////////////////////

`timescale 1ns/100ps
`default_nettype none

module proc_processing import proc_isa_pkg::*, proc_mem_pkg::*; #(
    parameter mem_id_t MEM_ID = 4'd2
) (
    input  wire               aclk,
    input  wire               aresetn,
    // Instruction channel
    input  wire               i_inst_valid,
    output logic              o_inst_ready,
    input  wire  inst_t       i_inst,
    output logic              o_busy,
    output lsu_exc_t          o_exc,
    // Register file, port 0 ALU and port 1 LSU
    output reg_rd_req_t       o_alu_rd_req,
    output reg_rd_req_t       o_lsu_rd_req,
    input  wire  reg_rd_val_t i_alu_rd_val,
    input  wire  reg_rd_val_t i_lsu_rd_val,
    output reg_wr_t           o_alu_wr,
    output reg_wr_t           o_lsu_wr,
    // Data memory
    output logic              o_mem_req_valid,
    output mem_req_t          o_mem_req,
    input  wire               i_mem_req_ready,
    input  wire               i_mem_rsp_valid,
    input  wire  mem_rsp_t    i_mem_rsp
);

    opcode_t    opcode;
    logic [6:0] funct7;
    logic       alu_inst;
    logic       ls_inst;
    logic       alu_valid;
    logic       alu_ready;
    logic       lsu_valid;
    logic       lsu_ready;
    logic       pending_read;

    ////////////////////
    // Decode and dispatch
    ////////////////////

    assign opcode = i_inst[6:0];
    assign funct7 = i_inst[31:25];

    assign alu_inst = ((opcode == OPC_OP) && (funct7 == F7_BASE || funct7 == F7_ALT))
                      || (opcode == OPC_OP_IMM);
    assign ls_inst  = (opcode == OPC_LOAD) || (opcode == OPC_STORE);

    // Unknown instructions are taken by the handshake and dropped
    assign alu_valid = i_inst_valid && lsu_ready && alu_inst && !pending_read;
    assign lsu_valid = i_inst_valid && alu_ready && ls_inst;

    assign o_inst_ready = alu_ready && lsu_ready;
    assign o_busy       = !o_inst_ready || pending_read;

    ////////////////////
    // Execution blocks
    ////////////////////

    proc_alu alu_i (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .i_valid  (alu_valid),
        .o_ready  (alu_ready),
        .i_inst   (i_inst),
        .o_rd_req (o_alu_rd_req),
        .i_rd_val (i_alu_rd_val),
        .o_wr     (o_alu_wr)
    );

    proc_lsu #(
        .MEM_ID (MEM_ID)
    ) lsu_i (
        .aclk            (aclk),
        .aresetn         (aresetn),
        .i_valid         (lsu_valid),
        .o_ready         (lsu_ready),
        .o_pending_read  (pending_read),
        .i_inst          (i_inst),
        .o_rd_req        (o_lsu_rd_req),
        .i_rd_val        (i_lsu_rd_val),
        .o_wr            (o_lsu_wr),
        .o_mem_req_valid (o_mem_req_valid),
        .o_mem_req       (o_mem_req),
        .i_mem_req_ready (i_mem_req_ready),
        .i_mem_rsp_valid (i_mem_rsp_valid),
        .i_mem_rsp       (i_mem_rsp),
        .o_exc           (o_exc)
    );

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
////////////////////
// Testbench clock and reset source
////////////////////

`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    output logic aclk,
    output logic aresetn
);

    initial begin
        aclk = 1'b0;
        forever begin
            #2 aclk = ~aclk;
        end
    end

    // Reset held for five cycles
    initial begin
        aresetn = 1'b0;
        repeat (5) @(posedge aclk);
        #1 aresetn = 1'b1;
    end

endmodule

`default_nettype wire

// ==== verification/tb_proc_processing.sv ====
////////////////////
// Testbench for the processing unit, random instruction stream
// against a register file, memory and ISA reference model
////////////////////

`timescale 1ns/100ps
`default_nettype none

module tb_proc_processing import proc_isa_pkg::*, proc_mem_pkg::*;;

    localparam mem_id_t TB_MEM_ID = 4'd2;
    localparam int      TIMEOUT   = 200;
    localparam int      NUM_INST  = 400;

    logic        aclk;
    logic        aresetn;
    logic        i_inst_valid;
    logic        o_inst_ready;
    inst_t       i_inst;
    logic        o_busy;
    lsu_exc_t    o_exc;
    reg_rd_req_t o_alu_rd_req;
    reg_rd_req_t o_lsu_rd_req;
    reg_rd_val_t i_alu_rd_val;
    reg_rd_val_t i_lsu_rd_val;
    reg_wr_t     o_alu_wr;
    reg_wr_t     o_lsu_wr;
    logic        o_mem_req_valid;
    mem_req_t    o_mem_req;
    logic        i_mem_req_ready;
    logic        i_mem_rsp_valid;
    mem_rsp_t    i_mem_rsp;

    xlen_t       rf [32];
    xlen_t       ref_regs [32];
    xlen_t       mem [64];
    xlen_t       ref_mem [64];
    logic [31:0] seed;
    logic [31:0] mem_seed;
    int          req_count;
    logic        rsp_pending;
    int          rsp_delay;
    mem_rsp_t    rsp_hold;

    tb_clock_gen clock_gen_i (
        .aclk    (aclk),
        .aresetn (aresetn)
    );

    proc_processing #(
        .MEM_ID (TB_MEM_ID)
    ) proc_processing_i (
        .aclk            (aclk),
        .aresetn         (aresetn),
        .i_inst_valid    (i_inst_valid),
        .o_inst_ready    (o_inst_ready),
        .i_inst          (i_inst),
        .o_busy          (o_busy),
        .o_exc           (o_exc),
        .o_alu_rd_req    (o_alu_rd_req),
        .o_lsu_rd_req    (o_lsu_rd_req),
        .i_alu_rd_val    (i_alu_rd_val),
        .i_lsu_rd_val    (i_lsu_rd_val),
        .o_alu_wr        (o_alu_wr),
        .o_lsu_wr        (o_lsu_wr),
        .o_mem_req_valid (o_mem_req_valid),
        .o_mem_req       (o_mem_req),
        .i_mem_req_ready (i_mem_req_ready),
        .i_mem_rsp_valid (i_mem_rsp_valid),
        .i_mem_rsp       (i_mem_rsp)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    ////////////////////
    // Compare tasks
    ////////////////////

    task automatic check_wr(input string name, input reg_wr_t exp, input reg_wr_t act);
        if (exp !== act) begin
            abort_run($sformatf("ERROR %s expected wr=%0b rd=%0d val=%h actual wr=%0b rd=%0d val=%h",
                name, exp.wr, exp.rd, exp.val, act.wr, act.rd, act.val));
        end
    endtask

    task automatic check_req(input string name, input mem_req_t exp, input mem_req_t act);
        if (exp !== act) begin
            abort_run($sformatf("ERROR %s expected req=%h actual req=%h", name, exp, act));
        end
    endtask

    task automatic check_exc(input string name, input lsu_exc_t exp, input lsu_exc_t act);
        if (exp !== act) begin
            abort_run($sformatf("ERROR %s expected exc=%b actual exc=%b", name, exp, act));
        end
    endtask

    task automatic check_word(input string name, input xlen_t exp, input xlen_t act);
        if (exp !== act) begin
            abort_run($sformatf("ERROR %s expected %h actual %h", name, exp, act));
        end
    endtask

    ////////////////////
    // Register file and memory models
    ////////////////////

    assign i_alu_rd_val = '{rs1_val: rf[o_alu_rd_req.rs1], rs2_val: rf[o_alu_rd_req.rs2]};
    assign i_lsu_rd_val = '{rs1_val: rf[o_lsu_rd_req.rs1], rs2_val: rf[o_lsu_rd_req.rs2]};

    always @(posedge aclk) begin
        if (o_alu_wr.wr && o_alu_wr.rd != 0) rf[o_alu_wr.rd] <= o_alu_wr.val;
        if (o_lsu_wr.wr && o_lsu_wr.rd != 0) rf[o_lsu_wr.rd] <= o_lsu_wr.val;
    end

    always @(posedge aclk) begin
        if (aresetn && o_mem_req_valid && i_mem_req_ready) begin
            req_count++;
            if (o_mem_req.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (o_mem_req.wstrb[b]) begin
                        mem[o_mem_req.addr[7:2]][b*8 +: 8] = o_mem_req.wdata[b*8 +: 8];
                    end
                end
            end else begin
                rsp_pending = 1'b1;
                rsp_delay   = mem_seed[19:18];
                rsp_hold    = '{rdata: mem[o_mem_req.addr[7:2]], id: o_mem_req.id};
            end
        end
        #1;
        i_mem_rsp_valid = 1'b0;
        if (rsp_pending) begin
            if (rsp_delay == 0) begin
                i_mem_rsp_valid = 1'b1;
                i_mem_rsp       = rsp_hold;
                rsp_pending     = 1'b0;
            end else begin
                rsp_delay--;
            end
        end
        mem_seed        = lcg_next(mem_seed);
        i_mem_req_ready = (mem_seed[29:28] != 2'b00);
    end

    ////////////////////
    // Reference model
    ////////////////////

    function automatic xlen_t ref_alu(input inst_t in, input xlen_t a, input xlen_t rb);
        logic  imm_form;
        xlen_t b;
        imm_form = (in[6:0] == OPC_OP_IMM);
        b = imm_form ? {{20{in[31]}}, in[31:20]} : rb;
        case (in[14:12])
            3'd0: return (in[30] && !imm_form) ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: return in[30] ? xlen_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic next_rand(output logic [31:0] r);
        seed = lcg_next(seed);
        r = seed;
    endtask

    task automatic wait_cycle(input int n);
        repeat (n) @(posedge aclk);
        #1;
    endtask

    // Hold the word until the handshake edge, then release valid
    task automatic issue(input inst_t in);
        int t;
        t = 0;
        i_inst       = in;
        i_inst_valid = 1'b1;
        while (!o_inst_ready) begin
            wait_cycle(1);
            t++;
            if (t > TIMEOUT) abort_run("Instruction was not accepted before the timeout");
        end
        wait_cycle(1);
        i_inst_valid = 1'b0;
    endtask

    task automatic run_alu(input logic reg_form);
        logic [31:0] r;
        funct3_t     f3;
        logic [6:0]  f7;
        reg_addr_t   rd;
        inst_t       in;
        xlen_t       val;
        next_rand(r);
        f3 = r[2:0];
        rd = r[7:3] % 31;
        f7 = ((f3 == 3'd0 && reg_form) || f3 == 3'd5) && r[8] ? F7_ALT : F7_BASE;
        if (reg_form) in = {f7, r[13:9], r[18:14], f3, rd, OPC_OP};
        else if (f3 == 3'd1 || f3 == 3'd5) in = {f7, r[13:9], r[18:14], f3, rd, OPC_OP_IMM};
        else in = {r[31:20], r[18:14], f3, rd, OPC_OP_IMM};
        val = ref_alu(in, ref_regs[in[19:15]], ref_regs[in[24:20]]);
        issue(in);
        check_wr("alu write-back", '{wr: rd != 0, rd: rd, val: val}, o_alu_wr);
        if (rd != 0) ref_regs[rd] = val;
    endtask

    task automatic run_mem(input logic store);
        logic [31:0] r;
        funct3_t     f3;
        int          size;
        xlen_t       imm;
        xlen_t       addr;
        xlen_t       w;
        reg_addr_t   rd;
        logic [3:0]  strb;
        int          count;
        int          t;
        next_rand(r);
        f3   = store ? funct3_t'(r[1:0] % 3) : funct3_t'(r[2] ? r[1:0] % 3 : 3'd4 + r[0]);
        size = (f3[1:0] == 2'd0) ? 1 : (f3[1:0] == 2'd1) ? 2 : 4;
        imm  = r[14:8] & ~(size - 1);
        if (size > 1 && r[17:16] == 2'b00) imm = imm | 1;
        addr = ref_regs[31] + imm;
        rd   = r[22:18] % 31;
        count = req_count;
        if (store) issue({imm[11:5], r[27:23], 5'd31, f3, imm[4:0], OPC_STORE});
        else issue({imm[11:0], 5'd31, f3, rd, OPC_LOAD});
        if (addr % size != 0) begin
            check_exc("misaligned access", store ? 2'b10 : 2'b01, o_exc);
            if (o_lsu_wr.wr || o_mem_req_valid)
                abort_run("Misaligned access touched memory or the register file");
            return;
        end
        if (store) begin
            strb = (size == 1) ? 4'b0001 << addr[1:0] : (size == 2) ? 4'b0011 << addr[1:0] : 4'hf;
            w    = ref_regs[r[27:23]] << (8 * addr[1:0]);
            check_req("store request", '{we: 1'b1, addr: {addr[31:2], 2'b00}, wdata: w,
                      wstrb: strb, id: TB_MEM_ID}, o_mem_req);
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) ref_mem[addr[7:2]][b*8 +: 8] = w[b*8 +: 8];
            end
            for (t = 0; !o_inst_ready; t++) begin
                if (t > TIMEOUT) abort_run("Store did not complete before the timeout");
                wait_cycle(1);
            end
            if (req_count != count + 1) abort_run("Store did not make exactly one request");
            check_word("memory after store", ref_mem[addr[7:2]], mem[addr[7:2]]);
        end else begin
            check_req("load request", '{we: 1'b0, addr: {addr[31:2], 2'b00}, wdata: o_mem_req.wdata,
                      wstrb: o_mem_req.wstrb, id: TB_MEM_ID}, o_mem_req);
            for (t = 0; !o_lsu_wr.wr; t++) begin
                if (t > TIMEOUT) abort_run("Load write-back did not arrive before the timeout");
                if (!o_busy) abort_run("Busy flag was low while a load was outstanding");
                wait_cycle(1);
            end
            w = ref_mem[addr[7:2]] >> (8 * addr[1:0]);
            case (f3)
                3'd0: w = {{24{w[7]}}, w[7:0]};
                3'd1: w = {{16{w[15]}}, w[15:0]};
                3'd4: w = {24'b0, w[7:0]};
                3'd5: w = {16'b0, w[15:0]};
                default: w = w;
            endcase
            check_wr("load write-back", '{wr: 1'b1, rd: rd, val: w}, o_lsu_wr);
            if (rd != 0) ref_regs[rd] = w;
        end
    endtask

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin
        logic [31:0] r;
        int          t;
        i_inst_valid    = 1'b0;
        i_inst          = '0;
        i_mem_req_ready = 1'b0;
        i_mem_rsp_valid = 1'b0;
        i_mem_rsp       = '0;
        seed            = 32'd76;
        mem_seed        = lcg_next(32'd76);
        req_count       = 0;
        rsp_pending     = 1'b0;
        for (int i = 0; i < 32; i++) begin
            rf[i]       = '0;
            ref_regs[i] = '0;
        end
        // Fill pattern derived from every address bit
        for (int i = 0; i < 64; i++) begin
            mem[i]     = (i * 32'h9e3779b1) ^ {i[7:0], ~i[7:0], i[7:0], 8'h5a};
            ref_mem[i] = mem[i];
        end
        t = 0;
        while (aresetn !== 1'b1) begin
            if (t > TIMEOUT) abort_run("Reset was not released before the timeout");
            @(posedge aclk);
            t++;
        end
        wait_cycle(1);
        if (o_alu_wr.wr || o_lsu_wr.wr || o_mem_req_valid || o_exc != 0 || !o_inst_ready)
            abort_run("Outputs were not idle after reset");
        for (int n = 0; n < NUM_INST; n++) begin
            next_rand(r);
            case (r[31:28])
                4'd0: begin
                    issue({5'b0, r[4:0], 2'b00, 5'd0, F3_ADD_SUB, 5'd31, OPC_OP_IMM});
                    check_wr("base setup", '{wr: 1'b1, rd: 5'd31, val: {r[4:0], 2'b00}}, o_alu_wr);
                    ref_regs[31] = {r[4:0], 2'b00};
                end
                4'd1, 4'd2, 4'd3, 4'd4, 4'd5: run_alu(1'b1);
                4'd6, 4'd7, 4'd8: run_alu(1'b0);
                4'd9, 4'd10, 4'd11: run_mem(1'b0);
                4'd12, 4'd13: run_mem(1'b1);
                default: begin
                    issue(r[0] ? {r[31:7], 7'b1110011} : {7'b0000001, r[24:7], OPC_OP});
                    if (o_alu_wr.wr || o_mem_req_valid || o_exc != 0)
                        abort_run("Unknown instruction changed the unit state");
                end
            endcase
            wait_cycle(1);
        end
        for (int i = 0; i < 32; i++) check_word("register file", ref_regs[i], rf[i]);
        for (int i = 0; i < 64; i++) check_word("memory contents", ref_mem[i], mem[i]);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
verilog/proc_isa_pkg.sv
verilog/proc_mem_pkg.sv
verilog/proc_alu.sv
verilog/proc_lsu.sv
verilog/proc_processing.sv
verification/tb_clock_gen.sv
verification/tb_proc_processing.sv

// ==== Bender.yml ====
package:
  name: proc_processing

sources:
  - verilog/proc_isa_pkg.sv
  - verilog/proc_mem_pkg.sv
  - verilog/proc_alu.sv
  - verilog/proc_lsu.sv
  - verilog/proc_processing.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/tb_proc_processing.sv
